/* filelist.f */
piano_ctrl_pkg.sv
piano_menu_next.sv
piano_genius_next.sv
piano_state_seq.sv
piano_ctrl_decode.sv
piano_control.sv
piano_control_assert.sv
tb_piano_control.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_piano_control
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_piano_control.sv */
// Directed testbench for the piano game control unit
// Walks the setup menu, freestyle play and genius rounds, and checks
// state_dbg and the decoded outputs after each clock edge

module tb_piano_control;

    localparam int clock_period    = 100;
    localparam int drive_delay     = 10;
    localparam int watchdog_cycles = 400;

    logic                          clock;
    logic                          reset;
    logic                          start;
    logic                          enter;
    piano_ctrl_pkg::play_status_t  status;
    piano_ctrl_pkg::menu_choice_t  choice;
    piano_ctrl_pkg::counter_ctrl_t counters;
    piano_ctrl_pkg::display_ctrl_t display;
    piano_ctrl_pkg::game_status_t  game;
    piano_ctrl_pkg::state_t        state_dbg;

    int error_count;
    int test_count;

    piano_control u_piano_control (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .enter     (enter),
        .status    (status),
        .choice    (choice),
        .counters  (counters),
        .display   (display),
        .game      (game),
        .state_dbg (state_dbg)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Tests need well under 100 cycles in all
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog timeout: the run did not end within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------
    // Inputs change and outputs are read just after each rising edge
    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic check_state(input piano_ctrl_pkg::state_t expected);
        if (state_dbg !== expected) begin
            $display("ERROR at time %0t: state_dbg expected %h, got %h",
                     $time, expected, state_dbg);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_sel(input piano_ctrl_pkg::menu_sel_t expected);
        if (display.menu_sel !== expected) begin
            $display("ERROR at time %0t: menu_sel expected %b, got %b",
                     $time, expected, display.menu_sel);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [11:0] expected,
                              input logic [11:0] actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic press_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic press_enter();
        enter = 1'b1;
        next_cycle();
        enter = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%s: %s, %0d mismatches", name,
                 (error_count == errors_before) ? "pass" : "FAIL", error_count - errors_before);
    endtask

    // From st_init through the shown sequence to the first reply
    task automatic play_to_reply();
        next_cycle();
        check_state(piano_ctrl_pkg::st_round_start);
        check_bit("inc_tone_timer", 1'b1, counters.inc_tone_timer);
        next_cycle();
        check_state(piano_ctrl_pkg::st_round_start);
        status.tone_timer_done = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_show);
        check_bit("clear_tone_timer", 1'b1, counters.clear_tone_timer);
        status.tone_timer_done = 1'b0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_show_wait);
        check_bit("leds_from_mem", 1'b1, display.leds_from_mem);
        status.beat_low      = 1'b1;
        status.addr_at_round = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_start);
        check_bit("clear_note_cnt", 1'b1, counters.clear_note_cnt);
        status.beat_low      = 1'b0;
        status.addr_at_round = 1'b0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_wait);
        check_bit("player_turn", 1'b1, game.player_turn);
        check_bit("inc_reply_timer", 1'b1, counters.inc_reply_timer);
        check_bit("clear_metro", 1'b1, counters.clear_metro);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic reset_checks();
        int                            errors_before;
        piano_ctrl_pkg::counter_ctrl_t idle_counters;
        errors_before = error_count;
        idle_counters = '0;
        idle_counters.clear_key_reg = 1'b1;
        check_state(piano_ctrl_pkg::st_idle);
        check_word("counters", idle_counters, counters);
        check_word("display", 12'h000, display);
        check_word("game", 12'h000, {9'h000, game});
        repeat (3) next_cycle();
        check_state(piano_ctrl_pkg::st_idle);
        report_test("reset", errors_before);
    endtask

    task automatic menu_free_walk();
        int errors_before;
        errors_before = error_count;
        choice.mode_free = 1'b1;
        press_start();
        check_state(piano_ctrl_pkg::st_menu_start);
        check_bit("menu_start", 1'b1, display.menu_start);
        next_cycle();
        check_state(piano_ctrl_pkg::st_wait_mode);
        check_bit("store_mode", 1'b1, display.store_mode);
        check_bit("menu_show", 1'b1, display.menu_show);
        check_sel(piano_ctrl_pkg::menu_sel_mode);
        press_enter();
        check_state(piano_ctrl_pkg::st_wait_bpm);
        check_bit("store_bpm", 1'b1, display.store_bpm);
        check_sel(piano_ctrl_pkg::menu_sel_bpm);
        press_enter();
        check_state(piano_ctrl_pkg::st_wait_key);
        check_bit("store_key", 1'b1, display.store_key);
        check_sel(piano_ctrl_pkg::menu_sel_key);
        // No song page in freestyle
        press_enter();
        check_state(piano_ctrl_pkg::st_init);
        check_bit("store_song", 1'b0, display.store_song);
        check_bit("menu_show", 1'b0, display.menu_show);
        check_bit("clear_round_cnt", 1'b1, counters.clear_round_cnt);
        check_bit("clear_reply_timer", 1'b1, counters.clear_reply_timer);
        check_bit("clear_metro", 1'b1, counters.clear_metro);
        report_test("menu in freestyle", errors_before);
    endtask

    task automatic free_play();
        int errors_before;
        errors_before = error_count;
        next_cycle();
        check_state(piano_ctrl_pkg::st_free_wait);
        check_bit("inc_metro", 1'b1, counters.inc_metro);
        status.key_held = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_play);
        check_bit("sound_on", 1'b1, display.sound_on);
        check_bit("leds_on", 1'b1, display.leds_on);
        check_bit("load_key_reg", 1'b1, counters.load_key_reg);
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_play);
        status.key_held = 1'b0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_free_wait);
        check_bit("inc_metro", 1'b1, counters.inc_metro);
        check_bit("sound_on", 1'b0, display.sound_on);
        // Without a mode the machine falls back to idle
        choice = '0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_idle);
        report_test("freestyle play", errors_before);
    endtask

    task automatic genius_win();
        int errors_before;
        errors_before = error_count;
        choice.mode_genius = 1'b1;
        press_start();
        check_state(piano_ctrl_pkg::st_menu_start);
        next_cycle();
        check_state(piano_ctrl_pkg::st_wait_mode);
        repeat (3) press_enter();
        check_state(piano_ctrl_pkg::st_wait_song);
        check_bit("store_song", 1'b1, display.store_song);
        check_sel(piano_ctrl_pkg::menu_sel_song);
        press_enter();
        check_state(piano_ctrl_pkg::st_init);
        play_to_reply();
        status.key_held = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_play);
        status               = '0;
        status.note_ok       = 1'b1;
        status.timing_ok     = 1'b1;
        status.addr_at_round = 1'b1;
        status.round_last    = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_compare);
        next_cycle();
        check_state(piano_ctrl_pkg::st_won);
        check_bit("won", 1'b1, game.won);
        check_bit("lost", 1'b0, game.lost);
        status = '0;
        press_start();
        check_state(piano_ctrl_pkg::st_init);
        report_test("genius win", errors_before);
    endtask

    task automatic wrong_note_retry();
        int errors_before;
        errors_before = error_count;
        play_to_reply();
        status.key_held = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_play);
        status.key_held  = 1'b0;
        status.timing_ok = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_compare);
        next_cycle();
        check_state(piano_ctrl_pkg::st_wrong_note);
        check_bit("lost", 1'b1, game.lost);
        check_bit("clear_reply_timer", 1'b1, counters.clear_reply_timer);
        status = '0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_err_menu_start);
        check_bit("lost", 1'b0, game.lost);
        check_bit("menu_start", 1'b1, display.menu_start);
        next_cycle();
        check_state(piano_ctrl_pkg::st_err_menu);
        check_bit("menu_show", 1'b1, display.menu_show);
        check_sel(piano_ctrl_pkg::menu_sel_error);
        next_cycle();
        check_state(piano_ctrl_pkg::st_err_menu);
        choice.retry_note = 1'b1;
        press_enter();
        check_state(piano_ctrl_pkg::st_note_start);
        choice.retry_note = 1'b0;
        report_test("wrong note and retry", errors_before);
    endtask

    task automatic timeout_replay();
        int errors_before;
        errors_before = error_count;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_wait);
        status.reply_timeout = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_wrong_time);
        check_bit("lost", 1'b1, game.lost);
        status.reply_timeout = 1'b0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_err_menu_start);
        next_cycle();
        check_state(piano_ctrl_pkg::st_err_menu);
        choice.replay_last = 1'b1;
        press_enter();
        check_state(piano_ctrl_pkg::st_show_last);
        check_bit("leds_from_mem", 1'b1, display.leds_from_mem);
        check_bit("inc_metro", 1'b1, counters.inc_metro);
        choice.replay_last = 1'b0;
        next_cycle();
        check_state(piano_ctrl_pkg::st_show_last);
        status.beat_low = 1'b1;
        next_cycle();
        check_state(piano_ctrl_pkg::st_note_wait);
        status.beat_low = 1'b0;
        report_test("reply timeout and replay", errors_before);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        error_count = 0;
        test_count  = 0;
        reset       = 1'b1;
        start       = 1'b0;
        enter       = 1'b0;
        status      = '0;
        choice      = '0;
        repeat (10) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        reset_checks();
        menu_free_walk();
        free_play();
        genius_win();
        wrong_note_retry();
        timeout_replay();

        $display("%0d tests run, %0d mismatches in total", test_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* piano_control_assert.sv */
// Concurrent checks on the piano control unit outputs
// Bound into every piano_control instance

module piano_control_assert (
    input logic                          clock,
    input logic                          reset,
    input piano_ctrl_pkg::counter_ctrl_t counters,
    input piano_ctrl_pkg::display_ctrl_t display,
    input piano_ctrl_pkg::game_status_t  game
);

    won_not_lost: assert property (@(posedge clock) disable iff (reset)
        !(game.won && game.lost))
        else $error("won and lost are high together");

    // Each wrong state is left after one cycle
    lost_one_cycle: assert property (@(posedge clock) disable iff (reset)
        game.lost |=> !game.lost)
        else $error("lost stayed high for more than one cycle");

    turn_counts_reply: assert property (@(posedge clock) disable iff (reset)
        game.player_turn |-> counters.inc_reply_timer)
        else $error("player_turn without inc_reply_timer");

    menu_start_then_show: assert property (@(posedge clock) disable iff (reset)
        display.menu_start |=> display.menu_show)
        else $error("menu_start not followed by menu_show");

endmodule

bind piano_control piano_control_assert u_piano_control_assert (
    .clock    (clock),
    .reset    (reset),
    .counters (counters),
    .display  (display),
    .game     (game)
);

/* piano_control.sv */
// Piano game control unit top level
// Sequencer and Moore output decode; the current state is also
// brought out for debug

module piano_control (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          enter,
    input  piano_ctrl_pkg::play_status_t  status,
    input  piano_ctrl_pkg::menu_choice_t  choice,
    output piano_ctrl_pkg::counter_ctrl_t counters,
    output piano_ctrl_pkg::display_ctrl_t display,
    output piano_ctrl_pkg::game_status_t  game,
    output piano_ctrl_pkg::state_t        state_dbg
);

    // Debug output doubles as the decode input
    piano_state_seq u_state_seq (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .enter  (enter),
        .status (status),
        .choice (choice),
        .state  (state_dbg)
    );

    piano_ctrl_decode u_ctrl_decode (
        .state    (state_dbg),
        .counters (counters),
        .display  (display),
        .game     (game)
    );

endmodule

/* piano_ctrl_decode.sv */
// Moore output decode for the piano control unit
// Turns the current state into counter strobes, display and sound
// controls, and the game status flags

module piano_ctrl_decode (
    input  piano_ctrl_pkg::state_t        state,
    output piano_ctrl_pkg::counter_ctrl_t counters,
    output piano_ctrl_pkg::display_ctrl_t display,
    output piano_ctrl_pkg::game_status_t  game
);

    // --------------------
    // Counters and timers
    // --------------------
    always_comb begin
        counters.clear_key_reg    = (state == piano_ctrl_pkg::st_idle);
        counters.load_key_reg     = (state == piano_ctrl_pkg::st_note_play);
        counters.clear_round_cnt  = (state == piano_ctrl_pkg::st_init);
        counters.inc_round_cnt    = (state == piano_ctrl_pkg::st_next_round);

        counters.clear_note_cnt   = (state == piano_ctrl_pkg::st_note_start ||
                                     state == piano_ctrl_pkg::st_round_start);
        counters.inc_note_cnt     = (state == piano_ctrl_pkg::st_next_step ||
                                     state == piano_ctrl_pkg::st_show_next ||
                                     state == piano_ctrl_pkg::st_next_note);

        counters.clear_tone_timer = (state == piano_ctrl_pkg::st_show ||
                                     state == piano_ctrl_pkg::st_init ||
                                     state == piano_ctrl_pkg::st_note_start);
        counters.inc_tone_timer   = (state == piano_ctrl_pkg::st_round_start);

        // Reply timer restarts before every expected note
        counters.clear_reply_timer = (state == piano_ctrl_pkg::st_next_note   ||
                                      state == piano_ctrl_pkg::st_note_start  ||
                                      state == piano_ctrl_pkg::st_init        ||
                                      state == piano_ctrl_pkg::st_wrong_note  ||
                                      state == piano_ctrl_pkg::st_wrong_time  ||
                                      state == piano_ctrl_pkg::st_check_end);
        counters.inc_reply_timer   = (state == piano_ctrl_pkg::st_note_wait);

        counters.clear_metro = (state == piano_ctrl_pkg::st_show        ||
                                state == piano_ctrl_pkg::st_wrong_note  ||
                                state == piano_ctrl_pkg::st_wrong_time  ||
                                state == piano_ctrl_pkg::st_note_wait   ||
                                state == piano_ctrl_pkg::st_init        ||
                                state == piano_ctrl_pkg::st_check_end);
        counters.inc_metro   = (state == piano_ctrl_pkg::st_show_last ||
                                state == piano_ctrl_pkg::st_show_wait ||
                                state == piano_ctrl_pkg::st_note_play ||
                                state == piano_ctrl_pkg::st_free_wait);
    end

    // --------------------
    // LEDs, sound, menus
    // --------------------
    always_comb begin
        display.leds_from_mem = (state == piano_ctrl_pkg::st_show_wait ||
                                 state == piano_ctrl_pkg::st_show_last);
        display.leds_on       = (state == piano_ctrl_pkg::st_note_play ||
                                 state == piano_ctrl_pkg::st_show_wait ||
                                 state == piano_ctrl_pkg::st_show_last);
        display.sound_on      = (state == piano_ctrl_pkg::st_note_play);

        display.menu_start = (state == piano_ctrl_pkg::st_menu_start ||
                              state == piano_ctrl_pkg::st_err_menu_start);
        display.menu_show  = (state == piano_ctrl_pkg::st_wait_mode ||
                              state == piano_ctrl_pkg::st_wait_bpm  ||
                              state == piano_ctrl_pkg::st_wait_key  ||
                              state == piano_ctrl_pkg::st_wait_song ||
                              state == piano_ctrl_pkg::st_err_menu);

        display.store_mode = (state == piano_ctrl_pkg::st_wait_mode);
        display.store_bpm  = (state == piano_ctrl_pkg::st_wait_bpm);
        display.store_key  = (state == piano_ctrl_pkg::st_wait_key);
        display.store_song = (state == piano_ctrl_pkg::st_wait_song);

        case (state)
            piano_ctrl_pkg::st_wait_bpm:  display.menu_sel = piano_ctrl_pkg::menu_sel_bpm;
            piano_ctrl_pkg::st_wait_key:  display.menu_sel = piano_ctrl_pkg::menu_sel_key;
            piano_ctrl_pkg::st_wait_song: display.menu_sel = piano_ctrl_pkg::menu_sel_song;
            piano_ctrl_pkg::st_err_menu:  display.menu_sel = piano_ctrl_pkg::menu_sel_error;
            default:                      display.menu_sel = piano_ctrl_pkg::menu_sel_mode;
        endcase
    end

    // Game status
    always_comb begin
        game.won         = (state == piano_ctrl_pkg::st_won);
        game.lost        = (state == piano_ctrl_pkg::st_wrong_note ||
                            state == piano_ctrl_pkg::st_wrong_time);
        game.player_turn = (state == piano_ctrl_pkg::st_note_wait);
    end

endmodule

/* piano_state_seq.sv */
// Piano control sequencer
// State register plus dispatch between the menu, genius and
// freestyle branches

module piano_state_seq (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         enter,
    input  piano_ctrl_pkg::play_status_t status,
    input  piano_ctrl_pkg::menu_choice_t choice,
    output piano_ctrl_pkg::state_t       state
);

    piano_ctrl_pkg::state_t menu_next;
    piano_ctrl_pkg::state_t genius_next;
    piano_ctrl_pkg::state_t free_next;
    piano_ctrl_pkg::state_t next_state;
    logic                   menu_owns;

    piano_menu_next u_menu_next (
        .state      (state),
        .start      (start),
        .enter      (enter),
        .choice     (choice),
        .next_state (menu_next),
        .menu_owns  (menu_owns)
    );

    piano_genius_next u_genius_next (
        .state      (state),
        .start      (start),
        .enter      (enter),
        .status     (status),
        .choice     (choice),
        .next_state (genius_next)
    );

    // Freestyle just follows the key
    always_comb begin
        case (state)
            piano_ctrl_pkg::st_free_wait, piano_ctrl_pkg::st_note_play:
                free_next = status.key_held ? piano_ctrl_pkg::st_note_play
                                            : piano_ctrl_pkg::st_free_wait;
            default:
                free_next = piano_ctrl_pkg::st_free_wait;
        endcase
    end

    always_comb begin
        if (menu_owns)
            next_state = menu_next;
        else if (choice.mode_genius)
            next_state = genius_next;
        else if (choice.mode_free)
            next_state = free_next;
        else
            next_state = piano_ctrl_pkg::st_idle;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= piano_ctrl_pkg::st_idle;
        else
            state <= next_state;
    end

endmodule

/* piano_genius_next.sv */
// Genius mode next-state logic
// Shows a growing sequence, checks each reply for note and timing,
// and runs the error menu with its retry and replay choices

module piano_genius_next (
    input  piano_ctrl_pkg::state_t       state,
    input  logic                         start,
    input  logic                         enter,
    input  piano_ctrl_pkg::play_status_t status,
    input  piano_ctrl_pkg::menu_choice_t choice,
    output piano_ctrl_pkg::state_t       next_state
);

    always_comb begin
        next_state = state;
        case (state)
            // --------------------
            // Sequence display
            // --------------------
            piano_ctrl_pkg::st_init: begin
                next_state = piano_ctrl_pkg::st_round_start;
            end
            piano_ctrl_pkg::st_round_start: begin
                if (status.tone_timer_done)
                    next_state = piano_ctrl_pkg::st_show;
            end
            piano_ctrl_pkg::st_show: begin
                next_state = piano_ctrl_pkg::st_show_wait;
            end
            piano_ctrl_pkg::st_show_wait: begin
                if (status.beat_low)
                    next_state = status.addr_at_round ? piano_ctrl_pkg::st_note_start
                                                      : piano_ctrl_pkg::st_show_next;
            end
            piano_ctrl_pkg::st_show_next: begin
                next_state = piano_ctrl_pkg::st_show;
            end

            // --------------------
            // Player reply
            // --------------------
            piano_ctrl_pkg::st_note_start: begin
                next_state = piano_ctrl_pkg::st_note_wait;
            end
            piano_ctrl_pkg::st_note_wait: begin
                // Timeout wins over a late key press
                if (status.reply_timeout)
                    next_state = piano_ctrl_pkg::st_wrong_time;
                else if (status.key_held)
                    next_state = piano_ctrl_pkg::st_note_play;
            end
            piano_ctrl_pkg::st_note_play: begin
                if (!status.key_held)
                    next_state = piano_ctrl_pkg::st_compare;
            end
            piano_ctrl_pkg::st_compare: begin
                if (!status.note_ok) begin
                    next_state = piano_ctrl_pkg::st_wrong_note;
                end else if (!status.timing_ok) begin
                    next_state = piano_ctrl_pkg::st_wrong_time;
                end else if (status.addr_at_round) begin
                    next_state = status.round_last ? piano_ctrl_pkg::st_won
                                                   : piano_ctrl_pkg::st_next_step;
                end else begin
                    next_state = piano_ctrl_pkg::st_next_note;
                end
            end
            piano_ctrl_pkg::st_next_note: begin
                next_state = piano_ctrl_pkg::st_note_wait;
            end

            // Round bookkeeping
            piano_ctrl_pkg::st_next_step: begin
                next_state = piano_ctrl_pkg::st_store;
            end
            piano_ctrl_pkg::st_store: begin
                next_state = piano_ctrl_pkg::st_check_end;
            end
            piano_ctrl_pkg::st_check_end: begin
                next_state = status.song_end ? piano_ctrl_pkg::st_won
                                             : piano_ctrl_pkg::st_next_round;
            end
            piano_ctrl_pkg::st_next_round: begin
                next_state = piano_ctrl_pkg::st_round_start;
            end
            piano_ctrl_pkg::st_won: begin
                if (start)
                    next_state = piano_ctrl_pkg::st_init;
            end

            // --------------------
            // Error menu
            // --------------------
            piano_ctrl_pkg::st_wrong_note, piano_ctrl_pkg::st_wrong_time: begin
                next_state = piano_ctrl_pkg::st_err_menu_start;
            end
            piano_ctrl_pkg::st_err_menu_start: begin
                next_state = piano_ctrl_pkg::st_err_menu;
            end
            piano_ctrl_pkg::st_err_menu: begin
                // No choice made yet keeps the menu up
                if (enter) begin
                    if (choice.retry_round)
                        next_state = piano_ctrl_pkg::st_round_start;
                    else if (choice.retry_note)
                        next_state = piano_ctrl_pkg::st_note_start;
                    else if (choice.replay_last)
                        next_state = piano_ctrl_pkg::st_show_last;
                end
            end
            piano_ctrl_pkg::st_show_last: begin
                if (status.beat_low)
                    next_state = piano_ctrl_pkg::st_note_wait;
            end
            default: begin
                next_state = piano_ctrl_pkg::st_idle;
            end
        endcase
    end

endmodule

/* piano_menu_next.sv */
// Setup menu next-state logic
// Covers idle and the mode, tempo, key and song pages, and flags
// when the current state belongs to this branch

module piano_menu_next (
    input  piano_ctrl_pkg::state_t       state,
    input  logic                         start,
    input  logic                         enter,
    input  piano_ctrl_pkg::menu_choice_t choice,
    output piano_ctrl_pkg::state_t       next_state,
    output logic                         menu_owns
);

    always_comb begin
        menu_owns  = 1'b1;
        next_state = state;
        case (state)
            piano_ctrl_pkg::st_idle: begin
                if (start)
                    next_state = piano_ctrl_pkg::st_menu_start;
            end
            piano_ctrl_pkg::st_menu_start: begin
                next_state = piano_ctrl_pkg::st_wait_mode;
            end
            piano_ctrl_pkg::st_wait_mode: begin
                if (enter)
                    next_state = piano_ctrl_pkg::st_wait_bpm;
            end
            piano_ctrl_pkg::st_wait_bpm: begin
                if (enter)
                    next_state = piano_ctrl_pkg::st_wait_key;
            end
            piano_ctrl_pkg::st_wait_key: begin
                // Freestyle has no song page
                if (enter)
                    next_state = choice.mode_free ? piano_ctrl_pkg::st_init
                                                  : piano_ctrl_pkg::st_wait_song;
            end
            piano_ctrl_pkg::st_wait_song: begin
                if (enter)
                    next_state = piano_ctrl_pkg::st_init;
            end
            default: begin
                menu_owns  = 1'b0;
                next_state = piano_ctrl_pkg::st_idle;
            end
        endcase
    end

endmodule

/* piano_ctrl_pkg.sv */
// Piano game control unit shared definitions
// State codes, menu page selectors and the structs that carry
// datapath flags, menu choices and control strobes

package piano_ctrl_pkg;

    localparam int state_w = 6;

    // --------------------
    // FSM state codes
    // --------------------
    typedef enum logic [state_w-1:0] {
        st_idle           = 6'h00,
        st_init           = 6'h01,
        st_round_start    = 6'h02,
        st_show           = 6'h03,
        st_show_wait      = 6'h04,
        st_show_next      = 6'h05,
        st_note_start     = 6'h06,
        st_note_wait      = 6'h07,
        st_compare        = 6'h09,
        st_won            = 6'h0A,
        st_next_note      = 6'h0B,
        st_next_step      = 6'h13,
        st_wrong_note     = 6'h14,
        st_wrong_time     = 6'h15,
        st_note_play      = 6'h17,
        st_show_last      = 6'h18,
        st_next_round     = 6'h19,
        st_check_end      = 6'h1A,
        st_store          = 6'h1B,
        st_menu_start     = 6'h1C,
        st_wait_mode      = 6'h1D,
        st_wait_bpm       = 6'h1E,
        st_wait_key       = 6'h1F,
        st_wait_song      = 6'h20,
        st_err_menu_start = 6'h21,
        st_err_menu       = 6'h22,
        st_free_wait      = 6'h23
    } state_t;

    // Menu page shown on the display
    typedef logic [2:0] menu_sel_t;

    localparam menu_sel_t menu_sel_mode  = 3'b000;
    localparam menu_sel_t menu_sel_bpm   = 3'b001;
    localparam menu_sel_t menu_sel_key   = 3'b010;
    localparam menu_sel_t menu_sel_song  = 3'b011;
    localparam menu_sel_t menu_sel_error = 3'b100;

    // --------------------
    // Datapath interface
    // --------------------
    typedef struct packed {
        logic tone_timer_done;
        logic round_last;
        logic key_held;
        logic note_ok;
        logic timing_ok;
        logic beat_low;
        logic addr_at_round;
        logic reply_timeout;
        logic song_end;
    } play_status_t;

    // Choices latched by the datapath from the menus
    typedef struct packed {
        logic mode_genius;
        logic mode_free;
        logic retry_round;
        logic retry_note;
        logic replay_last;
    } menu_choice_t;

    typedef struct packed {
        logic clear_note_cnt;
        logic inc_note_cnt;
        logic clear_tone_timer;
        logic inc_tone_timer;
        logic clear_round_cnt;
        logic inc_round_cnt;
        logic clear_metro;
        logic inc_metro;
        logic clear_reply_timer;
        logic inc_reply_timer;
        logic clear_key_reg;
        logic load_key_reg;
    } counter_ctrl_t;

    typedef struct packed {
        logic      leds_from_mem;
        logic      leds_on;
        logic      sound_on;
        logic      menu_show;
        logic      menu_start;
        menu_sel_t menu_sel;
        logic      store_mode;
        logic      store_bpm;
        logic      store_key;
        logic      store_song;
    } display_ctrl_t;

    typedef struct packed {
        logic won;
        logic lost;
        logic player_turn;
    } game_status_t;

endpackage
